// ==== project.f ====
hw/apu_pkg.sv
hw/apu_regs_pkg.sv
hw/osc_ctrl_if.sv
hw/apu_wb_regs.sv
hw/sine_wave_generator.sv
hw/pcm_gain_stage.sv
hw/apu_sine_top.sv
dv/apu_sine_asserts.sv
dv/apu_sine_tb.sv

// ==== hw/sine_quarter.hex ====
// quarter-wave sine, one signed 16-bit word per line, table index 0 to 63
0000
0324
0648
096A
0C8C
0FAB
12C8
15E2
18F9
1C0B
1F1A
2223
2528
2826
2B1F
2E11
30FB
33DE
36BA
398C
3C56
3F17
41CE
447A
471C
49B3
4C3F
4EBF
5133
539A
55F5
5842
5A82
5CB3
5ED7
60EB
62F1
64E7
66CE
68A6
6A6D
6C23
6DC9
6F5E
70E2
7254
73B5
7504
7641
776B
7884
7989
7A7C
7B5C
7C29
7CE3
7D89
7E1D
7E9C
7F09
7F61
7FA6
7FD8
7FF5

// ==== dv/apu_sine_tb.sv ====
`default_nettype none

module apu_sine_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int ADDR_W         = apu_pkg::DEFAULT_TABLE_ADDR_W;
    localparam int ROWS           = 8;
    // three register writes plus the edge before the first sample
    localparam int ROW_BUS_CYCLES = 7;
    // readback, disable and resume sections with a margin on top
    localparam int EXTRA_CYCLES   = 200;

    localparam logic [3:0] ADR_CTRL   = {apu_regs_pkg::REG_CTRL, 2'b00};
    localparam logic [3:0] ADR_STEP   = {apu_regs_pkg::REG_STEP, 2'b00};
    localparam logic [3:0] ADR_GAIN   = {apu_regs_pkg::REG_GAIN, 2'b00};
    localparam logic [3:0] ADR_SAMPLE = {apu_regs_pkg::REG_SAMPLE, 2'b00};

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [3:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic [15:0] pcm_o;

    logic [15:0] rom [1 << ADDR_W];
    integer      seed   = 32'h5b84_ff95;
    int          errors = 0;
    int          checks = 0;

    // stimulus table, rows 5 and 6 get random steps at run time
    logic [31:0] tbl_step [ROWS] = '{32'h03f0_0000, 32'h2345_6789, 32'h7fff_ffff,
                                     32'h0c00_0000, 32'h1000_0000, 32'h0, 32'h0,
                                     32'h0123_4567};
    logic [15:0] tbl_gain [ROWS] = '{16'h8000, 16'h8000, 16'h8000, 16'h4000,
                                     16'h0000, 16'h8000, 16'h6000, 16'h7fff};
    int          tbl_cycles [ROWS] = '{300, 40, 24, 80, 40, 60, 60, 120};
    string       tbl_name [ROWS] = '{"walk_every_entry", "cross_fast", "near_limit",
                                     "half_gain", "zero_gain", "random_a", "random_b",
                                     "odd_step"};

    // reference model state, mirrors the register block, phase and output pipeline
    logic [32:0] m_phase;
    int          m_quad;
    logic [15:0] m_sample;
    logic [15:0] m_pcm;
    logic        m_enable;
    logic [31:0] m_step;
    logic [15:0] m_gain;
    logic        m_ack;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    apu_sine_top #(
        .TABLE_ADDR_W (ADDR_W)
    ) dut_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .pcm_o    (pcm_o)
    );

    function automatic logic [15:0] apply_gain(input logic [15:0] sample,
                                               input logic [15:0] gain);
        longint product;
        product = longint'($signed(sample)) * longint'(gain);
        product = product >>> 15;
        return product[15:0];
    endfunction

    // quarters 2 and 3 (third and fourth) mirror the table below zero
    function automatic logic [15:0] table_sample(input logic [32:0] phase, input int quad);
        logic [15:0] word;
        word = rom[phase[31 -: ADDR_W]];
        return (quad >= 2) ? ~word : word;
    endfunction

    task automatic advance_phase();
        logic        ascending;
        logic [32:0] forward;
        logic [32:0] reverse;
        ascending = (m_quad == 0) || (m_quad == 2);
        forward   = ascending ? m_phase + {1'b0, m_step} : m_phase - {1'b0, m_step};
        reverse   = ascending ? m_phase - {1'b0, m_step} : m_phase + {1'b0, m_step};
        if (forward[32]) begin
            m_quad  = (m_quad + 1) % 4;
            m_phase = reverse;
        end else begin
            m_phase = forward;
        end
    endtask

    always @(posedge clk_i) begin : reference_model
        logic        req;
        logic        wr;
        logic [15:0] next_pcm;
        logic [15:0] next_sample;
        if (rst_i) begin
            m_phase  = '0;
            m_quad   = 0;
            m_sample = '0;
            m_pcm    = '0;
            m_enable = 1'b0;
            m_step   = '0;
            m_gain   = '0;
            m_ack    = 1'b0;
        end else begin
            req         = wb_cyc_i & wb_stb_i & ~m_ack;
            wr          = req & wb_we_i;
            next_pcm    = m_enable ? apply_gain(m_sample, m_gain) : 16'h0000;
            next_sample = m_enable ? table_sample(m_phase, m_quad) : 16'h0000;
            if (wr && (wb_adr_i[3:2] == apu_regs_pkg::REG_CTRL)
                && wb_dat_i[apu_regs_pkg::CTRL_START_BIT]) begin
                m_phase = '0;
                m_quad  = 0;
            end else if (m_enable) begin
                advance_phase();
            end
            m_pcm    = next_pcm;
            m_sample = next_sample;
            m_ack    = req;
            if (wr) begin
                case (wb_adr_i[3:2])
                    apu_regs_pkg::REG_CTRL: m_enable = wb_dat_i[apu_regs_pkg::CTRL_ENABLE_BIT];
                    apu_regs_pkg::REG_STEP: m_step = wb_dat_i;
                    apu_regs_pkg::REG_GAIN: m_gain = wb_dat_i[15:0];
                endcase
            end
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    // every bus task starts and ends 2 units after a rising edge
    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = data;
        @(posedge clk_i);
        #2;
        if (wb_ack_o !== 1'b1) begin
            errors = errors + 1;
            $display("error: write to address 0x%h was not acknowledged", adr);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge clk_i);
        #2;
        if (wb_ack_o !== 1'b0) begin
            errors = errors + 1;
            $display("error: ack stayed high after the write to address 0x%h", adr);
        end
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] data,
                           output logic [15:0] model_pcm);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        @(posedge clk_i);
        #2;
        if (wb_ack_o !== 1'b1) begin
            errors = errors + 1;
            $display("error: read from address 0x%h was not acknowledged", adr);
        end
        data      = wb_dat_o;
        model_pcm = m_pcm;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        @(posedge clk_i);
        #2;
        if (wb_ack_o !== 1'b0) begin
            errors = errors + 1;
            $display("error: ack stayed high after the read from address 0x%h", adr);
        end
    endtask

    task automatic follow_model(input string name, input int cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            #2;
            check(name, {16'h0000, m_pcm}, {16'h0000, pcm_o});
        end
    endtask

    // a start write while the tone runs must bring back table index 0 two edges after ack
    task automatic run_row(input int row);
        wb_write(ADR_STEP, tbl_step[row]);
        wb_write(ADR_GAIN, {16'h0000, tbl_gain[row]});
        wb_write(ADR_CTRL, 32'h0000_0003);
        @(posedge clk_i);
        #2;
        check({tbl_name[row], "_first"}, {16'h0000, apply_gain(rom[0], tbl_gain[row])},
              {16'h0000, pcm_o});
        follow_model(tbl_name[row], tbl_cycles[row]);
    endtask

    initial begin : stimulus
        logic [31:0] rd_data;
        logic [15:0] pcm_at_ack;
        rst_i    = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        $readmemh("hw/sine_quarter.hex", rom);
        tbl_step[5] = $random(seed) & 32'h7fff_ffff;
        tbl_step[6] = $random(seed) & 32'h7fff_ffff;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        check("reset_pcm", 32'h0, {16'h0000, pcm_o});

        wb_write(ADR_STEP, 32'h1234_5678);
        wb_read(ADR_STEP, rd_data, pcm_at_ack);
        check("step_readback", 32'h1234_5678, rd_data);
        wb_write(ADR_GAIN, 32'h0000_4000);
        wb_read(ADR_GAIN, rd_data, pcm_at_ack);
        check("gain_readback", 32'h0000_4000, rd_data);
        wb_write(ADR_CTRL, 32'h0000_0003);
        wb_read(ADR_CTRL, rd_data, pcm_at_ack);
        check("ctrl_start_reads_zero", 32'h0000_0001, rd_data);
        wb_write(ADR_CTRL, 32'h0000_0000);
        wb_read(ADR_CTRL, rd_data, pcm_at_ack);
        check("ctrl_cleared", 32'h0000_0000, rd_data);
        wb_write(ADR_SAMPLE, 32'hffff_ffff);
        wb_read(ADR_SAMPLE, rd_data, pcm_at_ack);
        check("sample_ignores_write", {{16{pcm_at_ack[15]}}, pcm_at_ack}, rd_data);

        for (int row = 0; row < ROWS; row++) begin
            run_row(row);
        end

        // the phase is held while disabled, so the tone picks up where it stopped
        wb_write(ADR_CTRL, 32'h0000_0000);
        @(posedge clk_i);
        #2;
        check("disable_quiet", 32'h0, {16'h0000, pcm_o});
        follow_model("disabled", 8);
        wb_write(ADR_CTRL, 32'h0000_0001);
        follow_model("resume", 60);
        wb_read(ADR_SAMPLE, rd_data, pcm_at_ack);
        check("sample_readback", {{16{pcm_at_ack[15]}}, pcm_at_ack}, rd_data);

        // failed bus and output properties count as errors too
        errors = errors + dut_i.u_asserts.failures;
        $display("closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        int budget;
        budget = RESET_CYCLES + EXTRA_CYCLES;
        foreach (tbl_cycles[i]) begin
            budget += tbl_cycles[i] + ROW_BUS_CYCLES;
        end
        #(budget * CLK_PERIOD);
        $display("error: watchdog expired after %0d cycles before the run finished", budget);
        $display("closing: %0d checks, %0d errors", checks, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule : apu_sine_tb

`default_nettype wire

// ==== dv/apu_sine_asserts.sv ====
`default_nettype none

module apu_sine_asserts (
    input logic        clk_i,
    input logic        rst_i,
    input logic        wb_cyc_i,
    input logic        wb_stb_i,
    input logic        wb_ack_i,
    input logic [15:0] pcm_i,
    input logic        enable_i
);

    // number of failed properties, added to the error count at the end of the run
    int failures = 0;

    // the slave only answers a strobe it saw on the previous edge
    ack_after_request : assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i)
    ) else begin
        failures = failures + 1;
        $error("ack raised without a request in the previous cycle");
    end

    ack_single_cycle : assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_ack_i |=> !wb_ack_i
    ) else begin
        failures = failures + 1;
        $error("ack held high for two cycles in a row");
    end

    // both output registers clear on the first edge that sees enable low
    output_quiet : assert property (
        @(posedge clk_i) disable iff (rst_i)
        $fell(enable_i) |=> (pcm_i == 16'h0000)
    ) else begin
        failures = failures + 1;
        $error("pcm output not zero two cycles after enable fell");
    end

endmodule : apu_sine_asserts

bind apu_sine_top apu_sine_asserts u_asserts (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o),
    .pcm_i    (pcm_o),
    .enable_i (ctrl_if.enable)
);

`default_nettype wire

// ==== hw/apu_sine_top.sv ====
`default_nettype none

module apu_sine_top #(
    parameter int TABLE_ADDR_W = apu_pkg::DEFAULT_TABLE_ADDR_W
) (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  apu_regs_pkg::wb_addr_t wb_adr_i,
    input  apu_regs_pkg::wb_data_t wb_dat_i,
    output apu_regs_pkg::wb_data_t wb_dat_o,
    output logic                   wb_ack_o,

    output apu_pkg::pcm_t          pcm_o
);

    // oscillator settings shared by the three blocks
    osc_ctrl_if ctrl_if ();

    // raw table sample before the gain is applied
    apu_pkg::pcm_t raw_sample;

    apu_wb_regs u_regs (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .sample_i (pcm_o),
        .ctrl     (ctrl_if.regs)
    );

    sine_wave_generator #(
        .TABLE_ADDR_W (TABLE_ADDR_W)
    ) u_osc (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .ctrl     (ctrl_if.osc),
        .sample_o (raw_sample)
    );

    pcm_gain_stage u_gain (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .ctrl     (ctrl_if.amp),
        .sample_i (raw_sample),
        .pcm_o    (pcm_o)
    );

endmodule : apu_sine_top

`default_nettype wire

// ==== hw/pcm_gain_stage.sv ====
`default_nettype none

module pcm_gain_stage (
    input  logic          clk_i,
    input  logic          rst_i,

    osc_ctrl_if.amp       ctrl,

    input  apu_pkg::pcm_t sample_i,
    output apu_pkg::pcm_t pcm_o
);

    apu_pkg::gain_prod_t product;
    apu_pkg::gain_prod_t scaled;

    // the gain is unsigned, so it gets a zero sign bit before the signed multiply
    assign product = sample_i * $signed({1'b0, ctrl.gain});

    // 0x8000 maps back to the input level after the shift
    assign scaled = product >>> apu_pkg::GAIN_SHIFT;

    always_ff @(posedge clk_i) begin
        if (rst_i || !ctrl.enable) begin
            pcm_o <= '0;
        end else begin
            // gains above unity can wrap here, the top bits are simply dropped
            pcm_o <= scaled[15:0];
        end
    end

endmodule : pcm_gain_stage

`default_nettype wire

// ==== hw/sine_wave_generator.sv ====
`default_nettype none

module sine_wave_generator #(
    parameter int TABLE_ADDR_W = apu_pkg::DEFAULT_TABLE_ADDR_W
) (
    input  logic          clk_i,
    input  logic          rst_i,

    osc_ctrl_if.osc       ctrl,

    output apu_pkg::pcm_t sample_o
);

    localparam int TABLE_DEPTH = 1 << TABLE_ADDR_W;

    // quarter-wave ROM, one word per table step from zero up to the peak
    apu_pkg::pcm_t sine_table [TABLE_DEPTH];

    initial begin
        $readmemh("hw/sine_quarter.hex", sine_table);
    end

    apu_pkg::phase_acc_t       phase_q;
    apu_pkg::phase_acc_t       phase_d;
    apu_pkg::phase_acc_t       phase_add;
    apu_pkg::phase_acc_t       phase_sub;
    apu_pkg::quadrant_t        quadrant_q;
    apu_pkg::quadrant_t        quadrant_d;

    logic [TABLE_ADDR_W-1:0]   table_idx;
    apu_pkg::pcm_t             table_word;
    logic                      negative_half;

    assign phase_add = phase_q + {1'b0, ctrl.inc_step};
    assign phase_sub = phase_q - {1'b0, ctrl.inc_step};

    // the phase walks the table up in odd quarters and back down in even ones
    // when a step would run past either end, the quarter ends and the step turns around
    always_comb begin
        phase_d    = phase_q;
        quadrant_d = quadrant_q;

        case (quadrant_q)
            apu_pkg::FIRST_QUARTER: begin
                if (phase_add[32]) begin
                    quadrant_d = apu_pkg::SECOND_QUARTER;
                    phase_d    = phase_sub;
                end else begin
                    phase_d = phase_add;
                end
            end
            apu_pkg::SECOND_QUARTER: begin
                if (phase_sub[32]) begin
                    quadrant_d = apu_pkg::THIRD_QUARTER;
                    phase_d    = phase_add;
                end else begin
                    phase_d = phase_sub;
                end
            end
            apu_pkg::THIRD_QUARTER: begin
                if (phase_add[32]) begin
                    quadrant_d = apu_pkg::FOURTH_QUARTER;
                    phase_d    = phase_sub;
                end else begin
                    phase_d = phase_add;
                end
            end
            apu_pkg::FOURTH_QUARTER: begin
                if (phase_sub[32]) begin
                    quadrant_d = apu_pkg::FIRST_QUARTER;
                    phase_d    = phase_add;
                end else begin
                    phase_d = phase_sub;
                end
            end
            default: begin
                quadrant_d = apu_pkg::FIRST_QUARTER;
                phase_d    = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || ctrl.start) begin
            phase_q    <= '0;
            quadrant_q <= apu_pkg::FIRST_QUARTER;
        end else if (ctrl.enable) begin
            phase_q    <= phase_d;
            quadrant_q <= quadrant_d;
        end
    end

    assign table_idx  = phase_q[31 -: TABLE_ADDR_W];
    assign table_word = sine_table[table_idx];

    // the second half period is the first one mirrored below zero
    assign negative_half = (quadrant_q == apu_pkg::THIRD_QUARTER)
                           || (quadrant_q == apu_pkg::FOURTH_QUARTER);

    // sample follows the phase one cycle late
    always_ff @(posedge clk_i) begin
        if (rst_i || !ctrl.enable) begin
            sample_o <= '0;
        end else if (negative_half) begin
            sample_o <= ~table_word;
        end else begin
            sample_o <= table_word;
        end
    end

endmodule : sine_wave_generator

`default_nettype wire

// ==== hw/apu_wb_regs.sv ====
`default_nettype none

module apu_wb_regs (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  apu_regs_pkg::wb_addr_t wb_adr_i,
    input  apu_regs_pkg::wb_data_t wb_dat_i,
    output apu_regs_pkg::wb_data_t wb_dat_o,
    output logic                   wb_ack_o,

    input  apu_pkg::pcm_t          sample_i,

    osc_ctrl_if.regs               ctrl
);

    apu_regs_pkg::reg_word_t word_sel;
    logic                    req;
    logic                    wr;

    logic                    enable_q;
    apu_pkg::phase_step_t    step_q;
    apu_pkg::gain_t          gain_q;

    assign word_sel = wb_adr_i[3:2];

    // a new access is accepted only while ack is low, so ack can never last two cycles
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr  = req & wb_we_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            enable_q <= 1'b0;
            step_q   <= '0;
            gain_q   <= '0;
        end else begin
            wb_ack_o <= req;

            // the write lands on the same edge that raises ack
            if (wr) begin
                case (word_sel)
                    apu_regs_pkg::REG_CTRL: begin
                        enable_q <= wb_dat_i[apu_regs_pkg::CTRL_ENABLE_BIT];
                    end
                    apu_regs_pkg::REG_STEP: begin
                        step_q <= wb_dat_i;
                    end
                    apu_regs_pkg::REG_GAIN: begin
                        gain_q <= wb_dat_i[15:0];
                    end
                    default: begin
                        // the sample register ignores writes
                    end
                endcase
            end
        end
    end

    // start is never stored, it is decoded straight from the accepted CTRL write
    // so the oscillator clears its phase on the ack edge itself
    assign ctrl.start = wr && (word_sel == apu_regs_pkg::REG_CTRL)
                        && wb_dat_i[apu_regs_pkg::CTRL_START_BIT];

    assign ctrl.enable   = enable_q;
    assign ctrl.inc_step = step_q;
    assign ctrl.gain     = gain_q;

    // the master holds the address through the ack cycle, so the mux can stay combinational
    always_comb begin
        wb_dat_o = '0;
        case (word_sel)
            apu_regs_pkg::REG_CTRL: begin
                wb_dat_o[apu_regs_pkg::CTRL_ENABLE_BIT] = enable_q;
            end
            apu_regs_pkg::REG_STEP: begin
                wb_dat_o = step_q;
            end
            apu_regs_pkg::REG_GAIN: begin
                wb_dat_o = {16'h0000, gain_q};
            end
            apu_regs_pkg::REG_SAMPLE: begin
                wb_dat_o = {{16{sample_i[15]}}, sample_i};
            end
            default: begin
                wb_dat_o = '0;
            end
        endcase
    end

endmodule : apu_wb_regs

`default_nettype wire

// ==== hw/osc_ctrl_if.sv ====
`default_nettype none

interface osc_ctrl_if;

    logic                 enable;
    // single-cycle pulse, restarts the phase from zero
    logic                 start;
    apu_pkg::phase_step_t inc_step;
    apu_pkg::gain_t       gain;

    // register block owns every setting
    modport regs (
        output enable,
        output start,
        output inc_step,
        output gain
    );

    modport osc (
        input enable,
        input start,
        input inc_step
    );

    // the gain stage only needs the level and the enable
    modport amp (
        input enable,
        input gain
    );

endinterface : osc_ctrl_if

`default_nettype wire

// ==== hw/apu_regs_pkg.sv ====
`default_nettype none

package apu_regs_pkg;

    // byte address on the bus, bits 3:2 select the register word
    typedef logic [3:0] wb_addr_t;

    typedef logic [31:0] wb_data_t;

    // word offset inside the register block
    typedef logic [1:0] reg_word_t;

    localparam reg_word_t REG_CTRL   = 2'd0;
    localparam reg_word_t REG_STEP   = 2'd1;
    localparam reg_word_t REG_GAIN   = 2'd2;
    // read only, returns the last output sample
    localparam reg_word_t REG_SAMPLE = 2'd3;

    // bit positions inside REG_CTRL
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_START_BIT  = 1;

endpackage : apu_regs_pkg

`default_nettype wire

// ==== hw/apu_pkg.sv ====
`default_nettype none

package apu_pkg;

    // signed PCM sample as it leaves the oscillator and the gain stage
    typedef logic signed [15:0] pcm_t;

    // phase increment per enabled clock, sets the tone frequency
    typedef logic [31:0] phase_step_t;

    // bit 32 flags the carry or borrow that closes a quarter period
    typedef logic [32:0] phase_acc_t;

    // unsigned gain, 0x8000 is unity
    typedef logic [15:0] gain_t;

    // full product of a signed sample and a zero-extended gain
    typedef logic signed [32:0] gain_prod_t;

    // product is scaled back by this many bits so that 0x8000 gives unity
    localparam int GAIN_SHIFT = 15;

    // the table holds one quarter period, so the FSM tracks which quarter we are in
    typedef enum logic [1:0] {
        FIRST_QUARTER,
        SECOND_QUARTER,
        THIRD_QUARTER,
        FOURTH_QUARTER
    } quadrant_t;

    localparam int DEFAULT_TABLE_ADDR_W = 6;

endpackage : apu_pkg

`default_nettype wire
